//--- Makefile
VERILATOR ?= verilator
TOP       := tb_exe_stage
FLIST     := project.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
SIM_ARGS  := +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         flush_i,
    input  logic                         start_i,
    input  logic                         signed_i,
    input  logic [exe_pkg::XLEN-1:0]     dividend_i,
    input  logic [exe_pkg::XLEN-1:0]     divisor_i,
    output logic                         done_o,
    output logic [exe_pkg::XLEN-1:0]     quotient_o,
    output logic [exe_pkg::XLEN-1:0]     remainder_o
);

    logic                             running_q;
    logic [exe_pkg::DIV_CNT_W-1:0]    cnt_q;
    logic [exe_pkg::XLEN-1:0]         rem_q;
    logic [exe_pkg::XLEN-1:0]         quo_q;
    logic [exe_pkg::XLEN-1:0]         dsr_q;
    logic                             neg_quo_q;
    logic                             neg_rem_q;
    logic                             zero_q;
    logic [exe_pkg::XLEN-1:0]         a_abs;
    logic [exe_pkg::XLEN-1:0]         b_abs;
    logic [exe_pkg::XLEN:0]           rem_sh;
    logic                             ge;

    assign a_abs  = (signed_i && dividend_i[exe_pkg::XLEN-1]) ? -dividend_i : dividend_i;
    assign b_abs  = (signed_i && divisor_i[exe_pkg::XLEN-1]) ? -divisor_i : divisor_i;
    assign rem_sh = {rem_q, quo_q[exe_pkg::XLEN-1]};  // next partial remainder
    assign ge     = rem_sh >= {1'b0, dsr_q};

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            running_q <= 1'b0;
            done_o    <= 1'b0;
            cnt_q     <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                running_q <= 1'b1;
                cnt_q     <= '0;
            end else if (running_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == exe_pkg::DIV_CNT_W'(exe_pkg::DIV_CYCLES - 1)) begin
                    running_q <= 1'b0;
                    done_o    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            rem_q     <= '0;
            quo_q     <= a_abs;
            dsr_q     <= b_abs;
            neg_quo_q <= signed_i & (dividend_i[exe_pkg::XLEN-1] ^ divisor_i[exe_pkg::XLEN-1]);
            neg_rem_q <= signed_i & dividend_i[exe_pkg::XLEN-1];
            zero_q    <= (divisor_i == '0);
        end else if (running_q) begin
            rem_q <= ge ? rem_sh[exe_pkg::XLEN-1:0] - dsr_q : rem_sh[exe_pkg::XLEN-1:0];
            quo_q <= {quo_q[exe_pkg::XLEN-2:0], ge};
        end
    end

    // x/0 gives all ones, remainder falls out as the dividend
    assign quotient_o  = zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
    assign remainder_o = neg_rem_q ? -rem_q : rem_q;

endmodule

//--- hdl/exe_pkg.sv
package exe_pkg;

    localparam int XLEN        = 32;
    localparam int MUL_LATENCY = 3;
    localparam int DIV_CYCLES  = 32;
    localparam int DIV_CNT_W   = $clog2(DIV_CYCLES);

    typedef enum logic [4:0] {
        op_add     = 5'd0,
        op_sub     = 5'd1,
        op_and     = 5'd2,
        op_or      = 5'd3,
        op_xor     = 5'd4,
        op_sll     = 5'd5,
        op_srl     = 5'd6,
        op_sra     = 5'd7,
        op_slt     = 5'd8,
        op_sltu    = 5'd9,
        op_mul_w   = 5'd10,
        op_mulh_w  = 5'd11,
        op_mulh_wu = 5'd12,
        op_div_w   = 5'd13,
        op_div_wu  = 5'd14,
        op_mod_w   = 5'd15,
        op_mod_wu  = 5'd16,
        op_ld_b    = 5'd17,
        op_ld_h    = 5'd18,
        op_ld_w    = 5'd19,
        op_st_b    = 5'd20,
        op_st_h    = 5'd21,
        op_st_w    = 5'd22,
        op_nop     = 5'd31
    } aluop_e;

    typedef enum logic [2:0] {
        sel_none  = 3'd0,
        sel_arith = 3'd1,
        sel_mul   = 3'd2,
        sel_div   = 3'd3,
        sel_mem   = 3'd4
    } alusel_e;

    typedef struct packed {
        aluop_e            aluop;
        alusel_e           alusel;
        logic [XLEN-1:0]   src1;
        logic [XLEN-1:0]   src2;
        logic [11:0]       imm;         // si12, sign-extended in the agu
        logic              reg_we;
        logic [4:0]        reg_waddr;
    } exe_issue_t;

    typedef struct packed {
        logic              we;
        logic [4:0]        waddr;
        logic [XLEN-1:0]   wdata;
        logic              excp;        // address alignment error
    } exe_wb_t;

    typedef struct packed {
        logic              valid;
        logic              we;
        logic [XLEN-1:0]   vaddr;
        logic [XLEN-1:0]   wdata;
        logic [3:0]        strb;
    } mem_req_t;

endpackage

//--- hdl/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  logic                   mem_stall_i,
    input  logic                   issue_valid_i,
    input  exe_pkg::exe_issue_t    issue_i,
    output logic                   stall_o,
    output logic                   wb_valid_o,
    output exe_pkg::exe_wb_t       wb_o,
    output exe_pkg::mem_req_t      mem_o
);

    logic [exe_pkg::XLEN-1:0]          alu_res;
    logic [exe_pkg::XLEN-1:0]          mc_a_q;
    logic [exe_pkg::XLEN-1:0]          mc_b_q;
    logic                              mc_signed_q;
    logic                              mc_busy_q;
    logic                              mc_rdy_q;
    logic                              mul_start_q;
    logic                              div_start_q;
    logic [exe_pkg::MUL_LATENCY-1:0]   mul_track_q;
    logic                              mul_done;
    logic                              div_done;
    logic [2*exe_pkg::XLEN-1:0]        product;
    logic [exe_pkg::XLEN-1:0]          quotient;
    logic [exe_pkg::XLEN-1:0]          remainder;
    exe_pkg::mem_req_t                 agu_req;
    logic                              misaligned;
    logic                              is_mul;
    logic                              is_div;
    logic                              is_mc;
    logic                              mc_go;
    logic                              unit_done;
    logic                              accept;
    logic [exe_pkg::XLEN-1:0]          wb_data;

    int_alu u_int_alu (.op_i(issue_i.aluop), .a_i(issue_i.src1), .b_i(issue_i.src2),
                       .result_o(alu_res));

    mul_unit u_mul_unit (.clk(clk), .rst_n_i(rst_n_i), .start_i(mul_start_q),
                         .signed_i(mc_signed_q), .a_i(mc_a_q), .b_i(mc_b_q),
                         .done_o(mul_done), .product_o(product));

    div_unit u_div_unit (.clk(clk), .rst_n_i(rst_n_i), .flush_i(flush_i),
                         .start_i(div_start_q), .signed_i(mc_signed_q),
                         .dividend_i(mc_a_q), .divisor_i(mc_b_q), .done_o(div_done),
                         .quotient_o(quotient), .remainder_o(remainder));

    lsu_agu u_lsu_agu (.op_i(issue_i.aluop), .base_i(issue_i.src1), .imm_i(issue_i.imm),
                       .store_data_i(issue_i.src2), .req_o(agu_req),
                       .misaligned_o(misaligned));

    assign is_mul    = (issue_i.alusel == exe_pkg::sel_mul);
    assign is_div    = (issue_i.alusel == exe_pkg::sel_div);
    assign is_mc     = issue_valid_i & (is_mul | is_div);
    assign mc_go     = is_mc & ~mc_busy_q & ~flush_i;
    // a flushed multiply may still drain out of the pipe, so match it to our start
    assign unit_done = is_mul ? (mul_done & mul_track_q[exe_pkg::MUL_LATENCY-1]) : div_done;
    assign stall_o   = mem_stall_i | (is_mc & ~(mc_rdy_q | unit_done));
    assign accept    = issue_valid_i & ~stall_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            mc_busy_q   <= 1'b0;
            mc_rdy_q    <= 1'b0;
            mul_start_q <= 1'b0;
            div_start_q <= 1'b0;
            mul_track_q <= '0;
        end else begin
            mul_start_q <= mc_go & is_mul;
            div_start_q <= mc_go & is_div;
            mul_track_q <= {mul_track_q[exe_pkg::MUL_LATENCY-2:0], mul_start_q};
            if (mc_go) begin
                mc_busy_q <= 1'b1;   // one start per instruction
            end
            if (unit_done && mc_busy_q) begin
                mc_rdy_q <= 1'b1;    // keeps the result while mem stalls
            end
            if (accept) begin
                mc_busy_q <= 1'b0;
                mc_rdy_q  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mc_go) begin
            mc_a_q      <= issue_i.src1;
            mc_b_q      <= issue_i.src2;
            mc_signed_q <= issue_i.aluop inside {exe_pkg::op_mul_w, exe_pkg::op_mulh_w,
                                                 exe_pkg::op_div_w, exe_pkg::op_mod_w};
        end
    end

    always_comb begin
        case (issue_i.alusel)
            exe_pkg::sel_arith: wb_data = alu_res;
            exe_pkg::sel_mul: begin
                wb_data = (issue_i.aluop == exe_pkg::op_mul_w) ? product[exe_pkg::XLEN-1:0]
                                                               : product[2*exe_pkg::XLEN-1:exe_pkg::XLEN];
            end
            exe_pkg::sel_div: begin
                wb_data = (issue_i.aluop inside {exe_pkg::op_div_w, exe_pkg::op_div_wu})
                          ? quotient : remainder;
            end
            default:            wb_data = '0;   // loads return data in mem
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            wb_valid_o  <= 1'b0;
            mem_o.valid <= 1'b0;
        end else if (!mem_stall_i) begin
            wb_valid_o  <= accept;
            wb_o.we     <= issue_i.reg_we;
            wb_o.waddr  <= issue_i.reg_waddr;
            wb_o.wdata  <= wb_data;
            wb_o.excp   <= misaligned;
            mem_o       <= agu_req;
            mem_o.valid <= accept & agu_req.valid;
        end
    end

endmodule

//--- hdl/int_alu.sv
`timescale 1ns/1ps

module int_alu (
    input  exe_pkg::aluop_e                op_i,
    input  logic [exe_pkg::XLEN-1:0]       a_i,
    input  logic [exe_pkg::XLEN-1:0]       b_i,
    output logic [exe_pkg::XLEN-1:0]       result_o
);

    logic [$clog2(exe_pkg::XLEN)-1:0] shamt;
    logic                             lt_s;
    logic                             lt_u;

    assign shamt = b_i[$clog2(exe_pkg::XLEN)-1:0];   // only low bits count
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (op_i)
            exe_pkg::op_add:  result_o = a_i + b_i;
            exe_pkg::op_sub:  result_o = a_i - b_i;
            exe_pkg::op_and:  result_o = a_i & b_i;
            exe_pkg::op_or:   result_o = a_i | b_i;
            exe_pkg::op_xor:  result_o = a_i ^ b_i;
            exe_pkg::op_sll:  result_o = a_i << shamt;
            exe_pkg::op_srl:  result_o = a_i >> shamt;
            exe_pkg::op_sra: begin
                result_o = $signed(a_i) >>> shamt;
            end
            exe_pkg::op_slt: begin
                result_o = {{(exe_pkg::XLEN-1){1'b0}}, lt_s};
            end
            exe_pkg::op_sltu: begin
                result_o = {{(exe_pkg::XLEN-1){1'b0}}, lt_u};
            end
            default:          result_o = '0;
        endcase
    end

endmodule

//--- hdl/lsu_agu.sv
`timescale 1ns/1ps

module lsu_agu (
    input  exe_pkg::aluop_e              op_i,
    input  logic [exe_pkg::XLEN-1:0]     base_i,
    input  logic [11:0]                  imm_i,
    input  logic [exe_pkg::XLEN-1:0]     store_data_i,
    output exe_pkg::mem_req_t            req_o,
    output logic                         misaligned_o
);

    logic [exe_pkg::XLEN-1:0] addr;
    logic                     is_mem;

    assign addr = base_i + {{(exe_pkg::XLEN-12){imm_i[11]}}, imm_i};

    always_comb begin
        req_o        = '0;
        req_o.vaddr  = addr;
        misaligned_o = 1'b0;
        is_mem       = 1'b1;
        case (op_i)
            exe_pkg::op_ld_b: begin
                req_o.strb = 4'b1111;
            end
            exe_pkg::op_ld_h: begin
                req_o.strb   = 4'b1111;
                misaligned_o = addr[0];
            end
            exe_pkg::op_ld_w: begin
                req_o.strb   = 4'b1111;
                misaligned_o = |addr[1:0];
            end
            exe_pkg::op_st_b: begin
                req_o.we    = 1'b1;
                req_o.strb  = 4'b0001 << addr[1:0];
                req_o.wdata = {{(exe_pkg::XLEN-8){1'b0}}, store_data_i[7:0]}
                              << {addr[1:0], 3'b000};
            end
            exe_pkg::op_st_h: begin
                req_o.we     = 1'b1;
                req_o.strb   = addr[1] ? 4'b1100 : 4'b0011;
                req_o.wdata  = {{(exe_pkg::XLEN-16){1'b0}}, store_data_i[15:0]}
                               << {addr[1], 4'b0000};
                misaligned_o = addr[0];
            end
            exe_pkg::op_st_w: begin
                req_o.we     = 1'b1;
                req_o.strb   = 4'b1111;
                req_o.wdata  = store_data_i;
                misaligned_o = |addr[1:0];
            end
            default: begin
                is_mem = 1'b0;
            end
        endcase
        req_o.valid = is_mem & ~misaligned_o;   // ale kills the request
    end

endmodule

//--- hdl/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             start_i,
    input  logic                             signed_i,
    input  logic [exe_pkg::XLEN-1:0]         a_i,
    input  logic [exe_pkg::XLEN-1:0]         b_i,
    output logic                             done_o,
    output logic [2*exe_pkg::XLEN-1:0]       product_o
);

    logic signed [exe_pkg::XLEN:0]       a_ext;
    logic signed [exe_pkg::XLEN:0]       b_ext;
    logic signed [2*exe_pkg::XLEN+1:0]   prod_full;
    logic [2*exe_pkg::XLEN-1:0]          pipe_q [exe_pkg::MUL_LATENCY];
    logic [exe_pkg::MUL_LATENCY-1:0]     vld_q;

    // one extra bit lets a single signed multiply cover both modes
    assign a_ext     = {signed_i & a_i[exe_pkg::XLEN-1], a_i};
    assign b_ext     = {signed_i & b_i[exe_pkg::XLEN-1], b_i};
    assign prod_full = a_ext * b_ext;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[exe_pkg::MUL_LATENCY-2:0], start_i};
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            pipe_q[0] <= prod_full[2*exe_pkg::XLEN-1:0];
        end
        for (int i = 1; i < exe_pkg::MUL_LATENCY; i++) begin
            if (vld_q[i-1]) begin
                pipe_q[i] <= pipe_q[i-1];    // last stage holds until refilled
            end
        end
    end

    assign done_o    = vld_q[exe_pkg::MUL_LATENCY-1];
    assign product_o = pipe_q[exe_pkg::MUL_LATENCY-1];

endmodule

//--- project.f
hdl/exe_pkg.sv
hdl/int_alu.sv
hdl/mul_unit.sv
hdl/div_unit.sv
hdl/lsu_agu.sv
hdl/exe_stage.sv
test/exe_stage_sva.sv
test/tb_exe_stage.sv

//--- test/exe_stage_sva.sv
`timescale 1ns/1ps

module exe_stage_sva (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  mem_stall_i,
    input  logic                  issue_valid_i,
    input  exe_pkg::exe_issue_t   issue_i,
    input  logic                  stall_o,
    input  logic                  wb_valid_o,
    input  exe_pkg::exe_wb_t      wb_o,
    input  exe_pkg::mem_req_t     mem_o
);

    exe_pkg::exe_wb_t    exp_wb;
    exe_pkg::mem_req_t   exp_mem;
    logic                accept;
    logic                is_mem;
    logic                is_mc;
    int unsigned         exp_stalls;
    int unsigned         stall_cnt;
    int unsigned         err_cnt = 0;    // watched by the testbench

    function automatic logic [31:0] model_data(exe_pkg::exe_issue_t i);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic signed [31:0] q_s;
        logic signed [31:0] r_s;
        logic [31:0]        q_u;
        logic [31:0]        r_u;
        logic signed [63:0] ps;
        logic [63:0]        pu;
        logic               ovf;
        sa  = i.src1;
        sb  = i.src2;
        ps  = 64'(sa) * 64'(sb);
        pu  = {32'b0, i.src1} * {32'b0, i.src2};
        ovf = (i.src1 == 32'h8000_0000) && (i.src2 == 32'hffff_ffff);
        q_s = i.src1;     // overflow case keeps the dividend
        r_s = '0;
        q_u = '1;
        r_u = i.src1;
        if (i.src2 != '0) begin
            q_u = i.src1 / i.src2;
            r_u = i.src1 % i.src2;
            if (!ovf) begin
                q_s = sa / sb;
                r_s = sa % sb;
            end
        end
        case (i.aluop)
            exe_pkg::op_add:     return i.src1 + i.src2;
            exe_pkg::op_sub:     return i.src1 - i.src2;
            exe_pkg::op_and:     return i.src1 & i.src2;
            exe_pkg::op_or:      return i.src1 | i.src2;
            exe_pkg::op_xor:     return i.src1 ^ i.src2;
            exe_pkg::op_sll:     return i.src1 << i.src2[4:0];
            exe_pkg::op_srl:     return i.src1 >> i.src2[4:0];
            exe_pkg::op_sra:     return sa >>> i.src2[4:0];
            exe_pkg::op_slt:     return {31'b0, sa < sb};
            exe_pkg::op_sltu:    return {31'b0, i.src1 < i.src2};
            exe_pkg::op_mul_w:   return pu[31:0];
            exe_pkg::op_mulh_w:  return ps[63:32];
            exe_pkg::op_mulh_wu: return pu[63:32];
            exe_pkg::op_div_w:   return (i.src2 == '0) ? '1 : q_s;
            exe_pkg::op_div_wu:  return q_u;
            exe_pkg::op_mod_w:   return (i.src2 == '0) ? i.src1 : r_s;
            exe_pkg::op_mod_wu:  return r_u;
            default:             return '0;
        endcase
    endfunction

    function automatic exe_pkg::mem_req_t model_mem(exe_pkg::exe_issue_t i);
        exe_pkg::mem_req_t r;
        logic [31:0]       addr;
        addr    = i.src1 + {{20{i.imm[11]}}, i.imm};
        r       = '0;
        r.vaddr = addr;
        r.strb  = 4'hf;
        r.valid = 1'b1;
        case (i.aluop)
            exe_pkg::op_ld_b: ;
            exe_pkg::op_ld_h: r.valid = ~addr[0];
            exe_pkg::op_ld_w: r.valid = (addr[1:0] == 2'b00);
            exe_pkg::op_st_b: begin
                r.we                      = 1'b1;
                r.strb                    = 4'b0000;
                r.strb[addr[1:0]]         = 1'b1;
                r.wdata[8*addr[1:0] +: 8] = i.src2[7:0];
            end
            exe_pkg::op_st_h: begin
                r.we                     = 1'b1;
                r.strb                   = 4'b0000;
                r.strb[2*addr[1] +: 2]   = 2'b11;
                r.wdata[16*addr[1] +: 16] = i.src2[15:0];
                r.valid                  = ~addr[0];
            end
            exe_pkg::op_st_w: begin
                r.we    = 1'b1;
                r.wdata = i.src2;
                r.valid = (addr[1:0] == 2'b00);
            end
            default: r.valid = 1'b0;
        endcase
        return r;
    endfunction

    assign accept     = issue_valid_i && !stall_o;
    assign is_mem     = issue_i.aluop inside {[exe_pkg::op_ld_b : exe_pkg::op_st_w]};
    assign is_mc      = issue_i.alusel inside {exe_pkg::sel_mul, exe_pkg::sel_div};
    assign exp_mem    = model_mem(issue_i);
    assign exp_wb     = '{we: issue_i.reg_we, waddr: issue_i.reg_waddr,
                          wdata: model_data(issue_i), excp: is_mem && !exp_mem.valid};
    assign exp_stalls = (issue_i.alusel == exe_pkg::sel_mul) ? exe_pkg::MUL_LATENCY + 1
                                                             : exe_pkg::DIV_CYCLES + 2;

    // stalled cycles of the instruction now on the issue port
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i || accept || !issue_valid_i) begin
            stall_cnt <= 0;
        end else if (stall_o) begin
            stall_cnt <= stall_cnt + 1;
        end
    end

    a_reset: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !stall_o && !wb_valid_o && !mem_o.valid)
        else begin
            $error("FAILED %0t: outputs not idle after reset", $time);
            err_cnt++;
        end

    a_wb: assert property (@(posedge clk) disable iff (!rst_n_i)
        accept && !flush_i |=> wb_valid_o && wb_o == $past(exp_wb))
        else begin
            $error("FAILED %0t: write-back bundle differs from the model", $time);
            err_cnt++;
        end

    a_mem: assert property (@(posedge clk) disable iff (!rst_n_i)
        accept && !flush_i |=> mem_o.valid == $past(exp_mem.valid)
                               && (!mem_o.valid || mem_o == $past(exp_mem)))
        else begin
            $error("FAILED %0t: memory request differs from the model", $time);
            err_cnt++;
        end

    a_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!accept && !mem_stall_i) || flush_i |=> !wb_valid_o && !mem_o.valid)
        else begin
            $error("FAILED %0t: output valid without an accepted issue", $time);
            err_cnt++;
        end

    a_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_stall_i |-> stall_o)
        else begin
            $error("FAILED %0t: stall_o low under a memory stall", $time);
            err_cnt++;
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_stall_i && !flush_i |=> $stable(wb_valid_o) && $stable(wb_o) && $stable(mem_o))
        else begin
            $error("FAILED %0t: outputs changed under a memory stall", $time);
            err_cnt++;
        end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        accept && !flush_i && is_mc |-> stall_cnt == exp_stalls)
        else begin
            $error("FAILED %0t: multi-cycle op stalled %0d cycles", $time, stall_cnt);
            err_cnt++;
        end

endmodule

//--- test/tb_exe_stage.sv
`timescale 1ns/1ps

module tb_exe_stage;

    localparam int TIMEOUT = 400 * (exe_pkg::DIV_CYCLES + 4);
    localparam logic [31:0] CORNERS [5] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                                            32'h8000_0000, 32'h7fff_ffff};

    logic                  clk;
    logic                  rst_n_i;
    logic                  flush_i;
    logic                  mem_stall_i;
    logic                  issue_valid_i;
    exe_pkg::exe_issue_t   issue_i;
    logic                  stall_o;
    logic                  wb_valid_o;
    exe_pkg::exe_wb_t      wb_o;
    exe_pkg::mem_req_t     mem_o;
    int                    cycle_cnt = 0;

    exe_stage dut0 (.*);

    bind exe_stage exe_stage_sva chk0 (
        .clk(clk), .rst_n_i(rst_n_i), .flush_i(flush_i), .mem_stall_i(mem_stall_i),
        .issue_valid_i(issue_valid_i), .issue_i(issue_i), .stall_o(stall_o),
        .wb_valid_o(wb_valid_o), .wb_o(wb_o), .mem_o(mem_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;    // 40 ns

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT || dut0.chk0.err_cnt != 0) begin
            if (cycle_cnt >= TIMEOUT) begin
                $display("timeout: test did not finish within %0d cycles", TIMEOUT);
            end else begin
                $display("a checker assertion failed, see the error above");
            end
            $display(">>> FAIL");
            $fatal(1, "run stopped");
        end
    end

    function automatic exe_pkg::alusel_e unit_of(exe_pkg::aluop_e op);
        if (op <= exe_pkg::op_sltu) return exe_pkg::sel_arith;
        if (op <= exe_pkg::op_mulh_wu) return exe_pkg::sel_mul;
        if (op <= exe_pkg::op_mod_wu) return exe_pkg::sel_div;
        if (op <= exe_pkg::op_st_w) return exe_pkg::sel_mem;
        return exe_pkg::sel_none;
    endfunction

    // called 2 ns after an edge, returns 2 ns after the accepting edge
    task automatic issue(input exe_pkg::aluop_e op, input logic [31:0] a,
                         input logic [31:0] b, input logic [11:0] imm, input int hold);
        issue_valid_i     = 1'b1;
        issue_i.aluop     = op;
        issue_i.alusel    = unit_of(op);
        issue_i.src1      = a;
        issue_i.src2      = b;
        issue_i.imm       = imm;
        issue_i.reg_we    = 1'($urandom);
        issue_i.reg_waddr = 5'($urandom);
        if (hold > 0) begin
            mem_stall_i = 1'b1;    // memory stage busy
            repeat (hold) @(posedge clk);
            #2 mem_stall_i = 1'b0;
        end
        #1;
        while (stall_o) begin
            @(posedge clk);
            #3;
        end
        @(posedge clk);
        #2 issue_valid_i = 1'b0;
    endtask

    task automatic flush_divide(input logic [31:0] a, input logic [31:0] b);
        issue_valid_i  = 1'b1;
        issue_i.aluop  = exe_pkg::op_div_w;
        issue_i.alusel = exe_pkg::sel_div;
        issue_i.src1   = a;
        issue_i.src2   = b;
        repeat (10) @(posedge clk);
        #2;
        flush_i        = 1'b1;    // divider is mid-way
        issue_i.aluop  = exe_pkg::op_st_w;    // store is taken and then killed
        issue_i.alusel = exe_pkg::sel_mem;
        issue_i.src1   = a & 32'hffff_fffc;
        issue_i.imm    = 12'h000;
        @(posedge clk);
        #2;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h649c_7425));
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        mem_stall_i   = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        repeat (5) @(posedge clk);
        #2 rst_n_i = 1'b1;

        for (int n = 0; n < 150; n++) begin
            issue(exe_pkg::aluop_e'($urandom_range(9, 0)), $urandom, $urandom, 12'h000,
                  (n % 20 == 7) ? 3 : 0);
        end
        for (int op = 10; op <= 16; op++) begin    // mul and div corners
            foreach (CORNERS[i]) begin
                foreach (CORNERS[j]) begin
                    issue(exe_pkg::aluop_e'(op), CORNERS[i], CORNERS[j], 12'h000, 0);
                end
            end
        end
        for (int n = 0; n < 60; n++) begin
            issue(exe_pkg::aluop_e'($urandom_range(16, 10)), $urandom,
                  (n % 15 == 0) ? 32'h0 : $urandom, 12'h000, 0);
        end
        for (int op = 17; op <= 22; op++) begin
            for (int off = 0; off < 4; off++) begin
                issue(exe_pkg::aluop_e'(op), $urandom & 32'hffff_fffc, $urandom,
                      12'({$urandom_range(1023, 0), 2'(off)}), (off == 2) ? 2 : 0);
            end
        end
        flush_divide($urandom, 32'd7);
        issue(exe_pkg::op_div_wu, $urandom, 32'd3, 12'h000, 0);
        issue(exe_pkg::op_add, $urandom, $urandom, 12'h000, 0);

        repeat (3) @(posedge clk);
        if (dut0.chk0.err_cnt != 0) begin
            $display(">>> FAIL");
            $fatal(1, "%0d checker assertion failures", dut0.chk0.err_cnt);
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule
